/* logic/tlk_link_macros.svh */
`ifndef TLK_LINK_MACROS_SVH
`define TLK_LINK_MACROS_SVH

// Payload words carried between the start word and the end word of a frame.
`define TLK_FRAME_LEN 8

// Idle words sent between the end word of one frame and the next start word.
`define TLK_IDLE_GAP 2

// Cycles that the PHY and the transceiver stay in reset after system reset.
// A board build would raise this to 65535.
`define TLK_PHY_RST_CYCLES 64

// Control words as {data[15:0], kmsb, klsb}.
// Idle is K28.5 in the low byte followed by D5.6 in the high byte.
`define TLK_K_IDLE {16'hC5BC, 1'b0, 1'b1}
// Start of frame is K27.7 in the low byte.
`define TLK_K_SOF {16'h00FB, 1'b0, 1'b1}
// End of frame is K29.7 in the low byte.
`define TLK_K_EOF {16'h00FD, 1'b0, 1'b1}

// Wishbone word addresses of the register file.
`define TLK_ADDR_CTRL 4'd0
`define TLK_ADDR_STATUS 4'd1
`define TLK_ADDR_PATTERN 4'd2
`define TLK_ADDR_FRAMES 4'd3
`define TLK_ADDR_ERRORS 4'd4

`endif

/* logic/tlk_link_pkg.sv */
`default_nettype none

package tlk_link_pkg;

    // Wishbone classic request from the host.
    // The address is a word address into the register file.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone classic response back to the host.
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // One 16-bit transceiver word with its two K-character flags.
    // The same layout serves the transmit and the receive side.
    typedef struct packed {
        logic [15:0] data;
        logic        kmsb;
        logic        klsb;
    } tlk_word_t;

    // Payload source for the framer and the checker.
    typedef enum logic [1:0] {
        MODE_COUNT = 2'd0,
        MODE_FIXED = 2'd1
    } tx_mode_e;

    // Control from the register file to the framer.
    // Start and stop are single-cycle pulses.
    typedef struct packed {
        logic        start;
        logic        stop;
        tx_mode_e    mode;
        logic [15:0] pattern;
    } tx_ctrl_t;

    // Receive statistics kept by the checker.
    typedef struct packed {
        logic [15:0] frames;
        logic [15:0] errors;
    } link_stats_t;

    typedef enum logic [2:0] {
        TX_OFF,
        TX_IDLE_GAP,
        TX_SOF,
        TX_PAYLOAD,
        TX_EOF
    } tx_state_e;

    typedef enum logic {
        RX_HUNT,
        RX_PAYLOAD
    } rx_state_e;

endpackage

`default_nettype wire

/* logic/tlk_power_seq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tlk_link_macros.svh"

module tlk_power_seq (
    input  wire         sys_clk_50,
    input  wire         sys_rstn,
    output logic        phy_resetn_o,
    output logic        enable_o,
    output logic        lckrefn_o,
    output logic        ready_o
);

    // Counts the reset hold time after system reset.
    logic [15:0] rst_cnt_q;
    // Set once the hold time has elapsed and held until the next reset.
    logic        done_q;

    // The counter runs from zero after reset and stops once done is set.
    // Done rises on the edge that completes the last hold cycle.
    always_ff @(posedge sys_clk_50) begin
        if (!sys_rstn) begin
            rst_cnt_q <= 16'd0;
            done_q    <= 1'b0;
        end else if (!done_q) begin
            rst_cnt_q <= rst_cnt_q + 16'd1;
            if (rst_cnt_q == 16'(`TLK_PHY_RST_CYCLES - 1)) begin
                done_q <= 1'b1;
            end
        end
    end

    // All pins leave reset together.
    // Lckrefn high lets the transceiver lock to its reference clock.
    assign phy_resetn_o = done_q;
    assign enable_o     = done_q;
    assign lckrefn_o    = done_q;
    // The framer and the status register see the same release edge.
    assign ready_o      = done_q;

endmodule

`default_nettype wire

/* logic/tlk_tx_framer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tlk_link_macros.svh"

module tlk_tx_framer import tlk_link_pkg::*; (
    input  wire            sys_clk_50,
    input  wire            sys_rstn,
    input  wire            ready_i,
    input  wire tx_ctrl_t  ctrl_i,
    output tlk_word_t      tx_o,
    output logic           running_o,
    output logic           stop_ack_o
);

    tx_state_e   state_q;
    // Shared counter for idle gap words and payload words.
    logic [7:0]  word_cnt_q;
    // Running payload counter for count mode.
    logic [15:0] pay_cnt_q;
    // Mode and pattern captured at each start word.
    tx_mode_e    mode_q;
    logic [15:0] pattern_q;
    // A stop request that waits for the end of the current frame.
    logic        stop_req_q;
    logic        stop_now;

    // A stop pulse in the same cycle as the decision point also counts.
    assign stop_now = stop_req_q | ctrl_i.stop;

    always_ff @(posedge sys_clk_50) begin
        if (!sys_rstn) begin
            state_q    <= TX_OFF;
            word_cnt_q <= 8'd0;
            pay_cnt_q  <= 16'd0;
            stop_req_q <= 1'b0;
            running_o  <= 1'b0;
            stop_ack_o <= 1'b0;
        end else begin
            stop_ack_o <= 1'b0;
            // Latch the stop request while streaming.
            if (ctrl_i.stop && (state_q != TX_OFF)) begin
                stop_req_q <= 1'b1;
            end
            case (state_q)
                TX_OFF: begin
                    // Streaming starts only once the transceiver is out of reset.
                    if (ctrl_i.start && ready_i) begin
                        state_q    <= TX_IDLE_GAP;
                        word_cnt_q <= 8'd0;
                        pay_cnt_q  <= 16'd0;
                        stop_req_q <= 1'b0;
                        running_o  <= 1'b1;
                    end
                end
                TX_IDLE_GAP: begin
                    // No frame is open here, so a stop takes effect at once.
                    if (stop_now) begin
                        state_q    <= TX_OFF;
                        stop_req_q <= 1'b0;
                        running_o  <= 1'b0;
                        stop_ack_o <= 1'b1;
                    end else if (word_cnt_q == 8'(`TLK_IDLE_GAP - 1)) begin
                        state_q    <= TX_SOF;
                        word_cnt_q <= 8'd0;
                    end else begin
                        word_cnt_q <= word_cnt_q + 8'd1;
                    end
                end
                TX_SOF: begin
                    state_q <= TX_PAYLOAD;
                end
                TX_PAYLOAD: begin
                    // The counter keeps running across frames.
                    pay_cnt_q <= pay_cnt_q + 16'd1;
                    if (word_cnt_q == 8'(`TLK_FRAME_LEN - 1)) begin
                        state_q    <= TX_EOF;
                        word_cnt_q <= 8'd0;
                    end else begin
                        word_cnt_q <= word_cnt_q + 8'd1;
                    end
                end
                TX_EOF: begin
                    // The frame is closed, so a pending stop ends streaming here.
                    if (stop_now) begin
                        state_q    <= TX_OFF;
                        stop_req_q <= 1'b0;
                        running_o  <= 1'b0;
                        stop_ack_o <= 1'b1;
                    end else begin
                        state_q <= TX_IDLE_GAP;
                    end
                end
                default: begin
                    state_q <= TX_OFF;
                end
            endcase
        end
    end

    // Mode and pattern are sampled while the start word goes out.
    always_ff @(posedge sys_clk_50) begin
        if (state_q == TX_SOF) begin
            mode_q    <= ctrl_i.mode;
            pattern_q <= ctrl_i.pattern;
        end
    end

    // Output word decode from the registered state.
    // K flags are set only on control words.
    always_comb begin
        case (state_q)
            TX_SOF: begin
                tx_o = `TLK_K_SOF;
            end
            TX_EOF: begin
                tx_o = `TLK_K_EOF;
            end
            TX_PAYLOAD: begin
                tx_o.data = (mode_q == MODE_FIXED) ? pattern_q : pay_cnt_q;
                tx_o.kmsb = 1'b0;
                tx_o.klsb = 1'b0;
            end
            default: begin
                tx_o = `TLK_K_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/tlk_rx_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tlk_link_macros.svh"

module tlk_rx_checker import tlk_link_pkg::*; (
    input  wire             sys_clk_50,
    input  wire             sys_rstn,
    input  wire tlk_word_t  rx_i,
    input  wire tx_mode_e   mode_i,
    input  wire [15:0]      pattern_i,
    input  wire             clear_i,
    output link_stats_t     stats_o
);

    // Receive word registered once at the input.
    tlk_word_t   rx_q;
    rx_state_e   state_q;
    // Next expected payload value in count mode.
    logic [15:0] exp_q;
    // Set once the count sequence has been seeded after a clear.
    logic        seeded_q;
    logic        is_sof;
    logic        is_eof;
    logic        is_data;
    logic        word_bad;

    always_ff @(posedge sys_clk_50) begin
        rx_q <= rx_i;
    end

    assign is_sof  = (rx_q == tlk_word_t'(`TLK_K_SOF));
    assign is_eof  = (rx_q == tlk_word_t'(`TLK_K_EOF));
    // Payload words carry no K flag at all.
    assign is_data = !rx_q.kmsb && !rx_q.klsb;

    // The first count word after a clear only seeds the sequence.
    always_comb begin
        if (mode_i == MODE_FIXED) begin
            word_bad = (rx_q.data != pattern_i);
        end else begin
            word_bad = seeded_q && (rx_q.data != exp_q);
        end
    end

    always_ff @(posedge sys_clk_50) begin
        if (!sys_rstn) begin
            state_q  <= RX_HUNT;
            stats_o  <= '0;
            seeded_q <= 1'b0;
        end else begin
            case (state_q)
                RX_HUNT: begin
                    if (is_sof) begin
                        state_q <= RX_PAYLOAD;
                    end
                end
                RX_PAYLOAD: begin
                    if (is_eof) begin
                        state_q        <= RX_HUNT;
                        stats_o.frames <= stats_o.frames + 16'd1;
                    end else if (is_data) begin
                        if (word_bad) begin
                            stats_o.errors <= stats_o.errors + 16'd1;
                        end
                        if (mode_i == MODE_COUNT) begin
                            seeded_q <= 1'b1;
                        end
                    end else if (!is_sof) begin
                        // Idle or a stray control word breaks the frame.
                        state_q <= RX_HUNT;
                    end
                end
                default: begin
                    state_q <= RX_HUNT;
                end
            endcase
            // Clearing wins over any count in the same cycle.
            if (clear_i) begin
                stats_o  <= '0;
                seeded_q <= 1'b0;
            end
        end
    end

    // The expected value follows its own sequence.
    // Received data only seeds it, so one bad word costs one error.
    always_ff @(posedge sys_clk_50) begin
        if ((state_q == RX_PAYLOAD) && is_data) begin
            exp_q <= (seeded_q ? exp_q : rx_q.data) + 16'd1;
        end
    end

endmodule

`default_nettype wire

/* logic/tlk_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tlk_link_macros.svh"

module tlk_wb_regs import tlk_link_pkg::*; (
    input  wire               sys_clk_50,
    input  wire               sys_rstn,
    input  wire wb_req_t      wb_req_i,
    output wb_rsp_t           wb_rsp_o,
    output tx_ctrl_t          ctrl_o,
    output logic              loopen_o,
    output logic              prbsen_o,
    input  wire               running_i,
    input  wire               stop_ack_i,
    input  wire               ready_i,
    input  wire link_stats_t  stats_i,
    output logic              clear_o
);

    logic        ack_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_mux;
    logic        access;
    logic        wr_en;
    logic        start_q;
    logic        stop_q;
    // Sticky flag that the framer acknowledged a stop.
    logic        stopped_q;
    tx_mode_e    mode_q;
    logic [15:0] pattern_q;

    // A new access is one that has not been acknowledged yet.
    // This keeps ack to a single cycle while the master still holds stb.
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_en  = access && wb_req_i.we;

    // Read data for the addressed register.
    always_comb begin
        case (wb_req_i.adr)
            `TLK_ADDR_CTRL: begin
                rd_mux = {26'd0, prbsen_o, loopen_o, mode_q, 2'b00};
            end
            `TLK_ADDR_STATUS: begin
                rd_mux = {29'd0, ready_i, stopped_q, running_i};
            end
            `TLK_ADDR_PATTERN: begin
                rd_mux = {16'd0, pattern_q};
            end
            `TLK_ADDR_FRAMES: begin
                rd_mux = {16'd0, stats_i.frames};
            end
            `TLK_ADDR_ERRORS: begin
                rd_mux = {16'd0, stats_i.errors};
            end
            default: begin
                rd_mux = 32'd0;
            end
        endcase
    end

    always_ff @(posedge sys_clk_50) begin
        if (!sys_rstn) begin
            ack_q     <= 1'b0;
            start_q   <= 1'b0;
            stop_q    <= 1'b0;
            clear_o   <= 1'b0;
            stopped_q <= 1'b0;
            loopen_o  <= 1'b0;
            prbsen_o  <= 1'b0;
            mode_q    <= MODE_COUNT;
            pattern_q <= 16'd0;
        end else begin
            ack_q   <= access;
            // Write strobes for start, stop and clear last one cycle.
            start_q <= wr_en && (wb_req_i.adr == `TLK_ADDR_CTRL) && wb_req_i.dat[0];
            stop_q  <= wr_en && (wb_req_i.adr == `TLK_ADDR_CTRL) && wb_req_i.dat[1];
            clear_o <= wr_en && (wb_req_i.adr == `TLK_ADDR_ERRORS);
            if (wr_en && (wb_req_i.adr == `TLK_ADDR_CTRL)) begin
                mode_q   <= tx_mode_e'(wb_req_i.dat[3:2]);
                loopen_o <= wb_req_i.dat[4];
                prbsen_o <= wb_req_i.dat[5];
            end
            if (wr_en && (wb_req_i.adr == `TLK_ADDR_PATTERN)) begin
                pattern_q <= wb_req_i.dat[15:0];
            end
            // A new start clears the flag.
            // Otherwise it holds the last stop acknowledge.
            if (start_q) begin
                stopped_q <= 1'b0;
            end else if (stop_ack_i) begin
                stopped_q <= 1'b1;
            end
        end
    end

    // Read data is captured with the access and held while ack is high.
    always_ff @(posedge sys_clk_50) begin
        if (access) begin
            rdata_q <= rd_mux;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdata_q;

    assign ctrl_o.start   = start_q;
    assign ctrl_o.stop    = stop_q;
    assign ctrl_o.mode    = mode_q;
    assign ctrl_o.pattern = pattern_q;

endmodule

`default_nettype wire

/* logic/tlk_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlk_link_top import tlk_link_pkg::*; (
    input  wire             sys_clk_50,
    input  wire             sys_rstn,
    input  wire wb_req_t    wb_req_i,
    output wb_rsp_t         wb_rsp_o,
    output tlk_word_t       tlk_tx_o,
    input  wire tlk_word_t  tlk_rx_i,
    output logic            loopen_o,
    output logic            prbsen_o,
    output logic            enable_o,
    output logic            lckrefn_o,
    output logic            phy_resetn_o
);

    // Framer controls from the register file.
    tx_ctrl_t    tx_ctrl;
    // Power-up done, seen by the framer and by STATUS.
    logic        ready;
    logic        running;
    logic        stop_ack;
    logic        stats_clear;
    link_stats_t stats;

    // Holds the PHY and the transceiver in reset after system reset.
    tlk_power_seq power_seq0 (
        .sys_clk_50   (sys_clk_50),
        .sys_rstn     (sys_rstn),
        .phy_resetn_o (phy_resetn_o),
        .enable_o     (enable_o),
        .lckrefn_o    (lckrefn_o),
        .ready_o      (ready)
    );

    tlk_tx_framer tx_framer0 (
        .sys_clk_50 (sys_clk_50),
        .sys_rstn   (sys_rstn),
        .ready_i    (ready),
        .ctrl_i     (tx_ctrl),
        .tx_o       (tlk_tx_o),
        .running_o  (running),
        .stop_ack_o (stop_ack)
    );

    // The checker follows the current register mode and pattern.
    tlk_rx_checker rx_checker0 (
        .sys_clk_50 (sys_clk_50),
        .sys_rstn   (sys_rstn),
        .rx_i       (tlk_rx_i),
        .mode_i     (tx_ctrl.mode),
        .pattern_i  (tx_ctrl.pattern),
        .clear_i    (stats_clear),
        .stats_o    (stats)
    );

    // Host access replaces the processor system of the board design.
    tlk_wb_regs wb_regs0 (
        .sys_clk_50 (sys_clk_50),
        .sys_rstn   (sys_rstn),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .ctrl_o     (tx_ctrl),
        .loopen_o   (loopen_o),
        .prbsen_o   (prbsen_o),
        .running_i  (running),
        .stop_ack_i (stop_ack),
        .ready_i    (ready),
        .stats_i    (stats),
        .clear_o    (stats_clear)
    );

endmodule

`default_nettype wire

/* tb/tb_tlk_link.sv */
`timescale 1ns/1ps
`default_nettype none
`include "tlk_link_macros.svh"

module tb_tlk_link import tlk_link_pkg::*; ();

    // One frame slot on the link holds the start word, the payload, the end word and the gap.
    localparam int FRAME_CYCLES = `TLK_FRAME_LEN + `TLK_IDLE_GAP + 2;
    localparam int MAX_TESTS = 8;
    localparam tlk_word_t W_IDLE = `TLK_K_IDLE;
    localparam tlk_word_t W_SOF = `TLK_K_SOF;
    localparam tlk_word_t W_EOF = `TLK_K_EOF;

    logic        sys_clk_50;
    logic        sys_rstn;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    tlk_word_t   tlk_tx;
    tlk_word_t   tlk_rx;
    logic        loopen;
    logic        prbsen;
    logic        enable;
    logic        lckrefn;
    logic        phy_resetn;

    // Each test takes five words for name code, mode, pattern, frame target and corruptions.
    logic [15:0] test_mem [0:5*MAX_TESTS-1];
    string       test_name;
    // Transmit monitor state.
    logic        quiet;
    logic        in_frame;
    logic        had_frame;
    int          pay_idx;
    int          idle_run;
    int          sof_cnt;
    int          eof_cnt;
    logic [15:0] exp_pay;
    tlk_word_t   exp_word;
    tx_mode_e    cur_mode;
    logic [15:0] cur_pattern;
    // Loopback path and corruption control.
    tlk_word_t   loop_next;
    int          corrupt_left;
    int          corrupt_done;
    int          corrupt_pos;
    int          flip_bit;
    logic [31:0] lfsr_q;
    int          cycle_cnt;
    int          cycle_limit;

    tlk_link_top dut0 (
        .sys_clk_50   (sys_clk_50),
        .sys_rstn     (sys_rstn),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .tlk_tx_o     (tlk_tx),
        .tlk_rx_i     (tlk_rx),
        .loopen_o     (loopen),
        .prbsen_o     (prbsen),
        .enable_o     (enable),
        .lckrefn_o    (lckrefn),
        .phy_resetn_o (phy_resetn)
    );

    initial begin
        sys_clk_50 = 1'b0;
        forever begin
            #10;
            sys_clk_50 = ~sys_clk_50;
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_word(input string what, input tlk_word_t exp, input tlk_word_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic compare_stats(input string what, input link_stats_t exp,
                                 input link_stats_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic expect_reg(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                      test_name, what, exp, act));
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once for every bit taken.
    function automatic int rand_bits(input int n);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    // Wishbone classic write that holds the request until the single ack cycle.
    task automatic bus_write(input logic [3:0] adr, input logic [31:0] dat);
        @(posedge sys_clk_50);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(posedge sys_clk_50);
            #1;
        end while (!wb_rsp.ack);
        wb_req = '0;
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [31:0] dat);
        @(posedge sys_clk_50);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = 32'd0;
        do begin
            @(posedge sys_clk_50);
            #1;
        end while (!wb_rsp.ack);
        // Read data is valid while ack is high.
        dat = wb_rsp.dat;
        wb_req = '0;
    endtask

    // Watchdog on the total run length.
    always @(posedge sys_clk_50) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run went past its limit of %0d clock cycles.", cycle_limit);
            $display("Finished with errors");
            $fatal(1, "Simulation stopped on timeout.");
        end
    end

    // The transmit monitor samples on the falling edge where the word is stable.
    // It also builds the next loopback word and injects the corruptions.
    always @(negedge sys_clk_50) begin
        loop_next = tlk_tx;
        if (tlk_tx === W_SOF) begin
            if (quiet || in_frame) begin
                stop_with_error("A start word appeared where no frame may start.");
            end
            if (had_frame) begin
                expect_reg("idle words between frames", `TLK_IDLE_GAP, idle_run);
            end
            in_frame = 1'b1;
            pay_idx  = 0;
            sof_cnt  = sof_cnt + 1;
            // Position 0 is never hit, so the count seed is never corrupted.
            corrupt_pos = 1 + (rand_bits(3) % (`TLK_FRAME_LEN - 1));
        end else if (tlk_tx === W_EOF) begin
            if (quiet || !in_frame) begin
                stop_with_error("An end word appeared outside a frame.");
            end
            expect_reg("payload words per frame", `TLK_FRAME_LEN, pay_idx);
            in_frame  = 1'b0;
            had_frame = 1'b1;
            idle_run  = 0;
            eof_cnt   = eof_cnt + 1;
        end else if (tlk_tx === W_IDLE) begin
            if (in_frame) begin
                stop_with_error("An idle word cut a frame short.");
            end
            idle_run = idle_run + 1;
        end else begin
            if (quiet || !in_frame) begin
                stop_with_error("A payload word appeared outside a frame.");
            end
            exp_word.data = (cur_mode == MODE_FIXED) ? cur_pattern : exp_pay;
            exp_word.kmsb = 1'b0;
            exp_word.klsb = 1'b0;
            check_word("payload word", exp_word, tlk_tx);
            exp_pay = exp_pay + 16'd1;
            // At most one data bit is flipped per frame and the K flags stay untouched.
            if ((corrupt_left > 0) && (pay_idx == corrupt_pos)) begin
                flip_bit = rand_bits(4);
                loop_next.data = loop_next.data ^ (16'd1 << flip_bit);
                corrupt_left = corrupt_left - 1;
                corrupt_done = corrupt_done + 1;
            end
            pay_idx = pay_idx + 1;
        end
    end

    // Loopback register from transmit to receive.
    always @(posedge sys_clk_50) begin
        #1;
        tlk_rx = loop_next;
    end

    initial begin
        int          t;
        int          n_tests;
        int          target;
        int          n_corrupt;
        logic [1:0]  mode_bits;
        logic [15:0] pattern;
        logic [31:0] rdata;
        logic [31:0] frames_rd;
        link_stats_t exp_stats;
        link_stats_t act_stats;

        wb_req       = '0;
        sys_rstn     = 1'b0;
        tlk_rx       = W_IDLE;
        loop_next    = W_IDLE;
        quiet        = 1'b1;
        in_frame     = 1'b0;
        had_frame    = 1'b0;
        pay_idx      = 0;
        idle_run     = 0;
        sof_cnt      = 0;
        eof_cnt      = 0;
        exp_pay      = 16'd0;
        cur_mode     = MODE_COUNT;
        cur_pattern  = 16'd0;
        corrupt_left = 0;
        corrupt_done = 0;
        corrupt_pos  = 1;
        lfsr_q       = 32'h0ad6_fae3;
        cycle_cnt    = 0;
        test_name    = "power-up";

        // The limit grows with each test's frame target.
        $readmemh("tb/tlk_link_testdata.txt", test_mem);
        cycle_limit = 4 + `TLK_PHY_RST_CYCLES + 400;
        n_tests = 0;
        while ((n_tests < MAX_TESTS) && (^test_mem[5*n_tests] !== 1'bx) &&
               (test_mem[5*n_tests] != 16'h0000)) begin
            cycle_limit = cycle_limit + (int'(test_mem[5*n_tests+3]) + 4) * FRAME_CYCLES + 200;
            n_tests = n_tests + 1;
        end
        if (n_tests == 0) begin
            stop_with_error("The test data file holds no tests.");
        end

        repeat (4) @(posedge sys_clk_50);
        #1;
        sys_rstn = 1'b1;

        // The three pins stay low through the hold time.
        // They rise together on the edge that completes it.
        for (int i = 1; i <= `TLK_PHY_RST_CYCLES; i++) begin
            @(posedge sys_clk_50);
            #1;
            expect_reg("reset pins", (i == `TLK_PHY_RST_CYCLES) ? 32'h7 : 32'h0,
                       {29'd0, lckrefn, enable, phy_resetn});
        end
        bus_read(`TLK_ADDR_STATUS, rdata);
        expect_reg("STATUS after power-up", 32'h4, rdata);

        for (t = 0; t < n_tests; t++) begin
            test_name = $sformatf("test %04h", test_mem[5*t]);
            mode_bits = test_mem[5*t+1][1:0];
            pattern   = test_mem[5*t+2];
            target    = int'(test_mem[5*t+3]);
            n_corrupt = int'(test_mem[5*t+4]);

            bus_write(`TLK_ADDR_PATTERN, {16'd0, pattern});
            bus_read(`TLK_ADDR_PATTERN, rdata);
            expect_reg("PATTERN readback", {16'd0, pattern}, rdata);
            // A write to ERRORS clears both counters.
            bus_write(`TLK_ADDR_ERRORS, 32'd0);
            bus_read(`TLK_ADDR_FRAMES, frames_rd);
            bus_read(`TLK_ADDR_ERRORS, rdata);
            act_stats = {frames_rd[15:0], rdata[15:0]};
            compare_stats("statistics after clear", '0, act_stats);

            cur_mode     = tx_mode_e'(mode_bits);
            cur_pattern  = pattern;
            exp_pay      = 16'd0;
            had_frame    = 1'b0;
            sof_cnt      = 0;
            eof_cnt      = 0;
            corrupt_left = n_corrupt;
            corrupt_done = 0;
            quiet        = 1'b0;
            bus_write(`TLK_ADDR_CTRL, {28'd0, mode_bits, 2'b01});

            while (eof_cnt < target) begin
                @(posedge sys_clk_50);
            end
            bus_write(`TLK_ADDR_CTRL, {28'd0, mode_bits, 2'b10});
            do begin
                bus_read(`TLK_ADDR_STATUS, rdata);
            end while (rdata[0]);
            expect_reg("STATUS after stop", 32'h6, rdata);
            // Once running is clear every frame that was opened has been closed.
            expect_reg("start words against end words", sof_cnt, eof_cnt);
            // Only idle words may follow, which the monitor enforces.
            quiet = 1'b1;
            repeat (2 * FRAME_CYCLES) @(posedge sys_clk_50);
            if (corrupt_left != 0) begin
                stop_with_error("The stream ended before every corruption was injected.");
            end

            bus_read(`TLK_ADDR_FRAMES, frames_rd);
            bus_read(`TLK_ADDR_ERRORS, rdata);
            exp_stats.frames = 16'(eof_cnt);
            exp_stats.errors = 16'(corrupt_done);
            act_stats = {frames_rd[15:0], rdata[15:0]};
            compare_stats("receive statistics", exp_stats, act_stats);
        end

        // Loopback and PRBS only reach the pins.
        test_name = "pass-through";
        bus_write(`TLK_ADDR_CTRL, 32'h34);
        expect_reg("loopen and prbsen pins", 32'h3, {30'd0, prbsen, loopen});
        bus_read(`TLK_ADDR_CTRL, rdata);
        expect_reg("CTRL readback", 32'h34, rdata);
        bus_write(`TLK_ADDR_CTRL, 32'h10);
        expect_reg("loopen and prbsen pins", 32'h1, {30'd0, prbsen, loopen});
        bus_read(`TLK_ADDR_CTRL, rdata);
        expect_reg("CTRL readback", 32'h10, rdata);
        repeat (FRAME_CYCLES) @(posedge sys_clk_50);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tlk_link_testdata.txt */
// Columns in hex: name code, mode (0 count, 1 fixed), pattern, frame target, corruptions.
// A line of zeros ends the list.
0c01 0 1234 4 0
0f02 1 a5c3 3 0
0c03 0 0000 6 2
0f04 1 5a17 5 3
0c05 0 beef a 4
0f06 1 ffff 2 1
0000 0 0000 0 0

/* vlog.f */
+incdir+logic
logic/tlk_link_pkg.sv
logic/tlk_power_seq.sv
logic/tlk_tx_framer.sv
logic/tlk_rx_checker.sv
logic/tlk_wb_regs.sv
logic/tlk_link_top.sv
tb/tb_tlk_link.sv
